// File: Makefile
# Verilator build and run of the analog front end testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := afe_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation FAILED"; exit 1)
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: analog/adc_frontend.sv
//////////////////////////////////////////////////////////////////////
// ADC front end
// Pin registers, negative-slope to two's complement conversion,
// digital loopback select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adc_frontend import afe_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  input  logic                 digital_loop_i,
  input  smp_t                 loop_a_i,        // Saturated DAC samples
  input  smp_t                 loop_b_i,
  output smp_t                 adc_a_o,
  output smp_t                 adc_b_o
);

logic [SMP_W-1:0] raw_a, raw_b;  // Registered pin codes

// Low reserved bits dropped at the pins
always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    raw_a <= ADC_MID_CODE;  // Reads as zero
    raw_b <= ADC_MID_CODE;
  end
  else
  begin
    raw_a <= adc_dat_a_i[ADC_RAW_W-1 -: SMP_W];
    raw_b <= adc_dat_b_i[ADC_RAW_W-1 -: SMP_W];
  end
end

// Loopback bypasses the pin register
assign adc_a_o = digital_loop_i ? loop_a_i : smp_t'(slope_flip(raw_a));
assign adc_b_o = digital_loop_i ? loop_b_i : smp_t'(slope_flip(raw_b));

endmodule

// File: analog/dac_mixer.sv
//////////////////////////////////////////////////////////////////////
// DAC mixer
// Generator plus feedback sum, saturation to 14 bits,
// negative-slope DAC code output registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_mixer import afe_pkg::*; (
  input  logic             adc_clk,
  input  logic             dac_rst_i,    // Holds both DAC words at zero
  input  smp_t             gen_a_i,
  input  smp_t             gen_b_i,
  input  smp_t             fb_a_i,
  input  smp_t             fb_b_i,
  output smp_t             sat_a_o,      // Saturated sum, combinational
  output smp_t             sat_b_o,
  output logic [SMP_W-1:0] dac_dat_a_o,
  output logic [SMP_W-1:0] dac_dat_b_o
);

logic signed [SUM_W-1:0] sum_a, sum_b;

// Clamp to full scale when the guard bit disagrees with the sign
function automatic smp_t saturate(input logic signed [SUM_W-1:0] s);
  if (s[SUM_W-1] != s[SUM_W-2])
    return {s[SUM_W-1], {(SMP_W-1){~s[SUM_W-1]}}};
  return s[SMP_W-1:0];
endfunction

// Sign extended into the guard bit
assign sum_a = gen_a_i + fb_a_i;
assign sum_b = gen_b_i + fb_b_i;

assign sat_a_o = saturate(sum_a);
assign sat_b_o = saturate(sum_b);

//////////////////////////////////////////////////////////////////////
// Output registers
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  if (dac_rst_i)
  begin
    dac_dat_a_o <= '0;
    dac_dat_b_o <= '0;
  end
  else
  begin
    dac_dat_a_o <= slope_flip(sat_a_o);  // Back to neg-slope code
    dac_dat_b_o <= slope_flip(sat_b_o);
  end
end

endmodule

// File: common/afe_pkg.sv
//////////////////////////////////////////////////////////////////////
// Analog front end shared definitions
// Data widths, PWM and bus sizes, DAC reset hold length
// Register map, ID word, reset sequencer states
// Negative-slope code conversion
//////////////////////////////////////////////////////////////////////

package afe_pkg;

  // Sample path
  localparam int ADC_RAW_W = 16;  // ADC pin word
  localparam int SMP_W     = 14;  // Sample width
  localparam int SUM_W     = 15;  // Mixer sum, one guard bit

  // Unsigned code that converts to a zero sample
  localparam logic [SMP_W-1:0] ADC_MID_CODE = {1'b0, {(SMP_W-1){1'b1}}};

  typedef logic signed [SMP_W-1:0] smp_t;

  // PWM DACs
  localparam int PWM_W      = 8;
  localparam int PWM_N      = 4;
  localparam int PWM_PERIOD = 2**PWM_W;  // Cycles per period

  // Reset sequencing
  localparam int DAC_RST_CYCLES = 16;
  localparam int DAC_CNT_W      = $clog2(DAC_RST_CYCLES + 1);

  // Strobe bus
  localparam int BUS_AW = 8;
  localparam int BUS_DW = 32;
  localparam logic [BUS_DW-1:0] AFE_ID = 32'h0AFE_0001;

  // Register byte addresses
  typedef enum logic [BUS_AW-1:0] {
    REG_ID   = 8'h00,  // Read only
    REG_CTRL = 8'h04,  // Bit 0 digital loopback
    REG_PWM0 = 8'h10,
    REG_PWM1 = 8'h14,
    REG_PWM2 = 8'h18,
    REG_PWM3 = 8'h1C
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_WAIT_LOCK,  // Core and DAC in reset
    ST_DAC_RST,    // Core running, DAC still held
    ST_RUN
  } rst_state_e;

  // Negative-slope unsigned <-> two's complement, same op both ways
  function automatic logic [SMP_W-1:0] slope_flip(input logic [SMP_W-1:0] code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

endpackage

// File: hdl/afe_regs.sv
//////////////////////////////////////////////////////////////////////
// Register block on the strobe bus
// ID word, control bit for digital loopback, four PWM duties
// One-cycle ack per strobe, error on unmapped address
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_regs import afe_pkg::*; (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  // Strobe bus
  input  logic [BUS_AW-1:0]           sys_addr_i,
  input  logic [BUS_DW-1:0]           sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic [BUS_DW-1:0]           sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        sys_err_o,
  // Configuration
  output logic                        digital_loop_o,
  output logic [PWM_N-1:0][PWM_W-1:0] duty_o
);

logic [BUS_DW-1:0] rd_data;   // Read mux
logic              addr_hit;  // Address is in the map

//////////////////////////////////////////////////////////////////////
// Address decode and read mux
//////////////////////////////////////////////////////////////////////

always_comb
begin
  addr_hit = 1'b1;
  rd_data  = '0;
  case (sys_addr_i)
    REG_ID:   rd_data = AFE_ID;
    REG_CTRL: rd_data = BUS_DW'(digital_loop_o);
    REG_PWM0: rd_data = BUS_DW'(duty_o[0]);
    REG_PWM1: rd_data = BUS_DW'(duty_o[1]);
    REG_PWM2: rd_data = BUS_DW'(duty_o[2]);
    REG_PWM3: rd_data = BUS_DW'(duty_o[3]);
    default:  addr_hit = 1'b0;  // Reads back zero
  endcase
end

//////////////////////////////////////////////////////////////////////
// Write path and response
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    sys_ack_o      <= 1'b0;
    sys_err_o      <= 1'b0;
    digital_loop_o <= 1'b0;
    duty_o         <= '0;
  end
  else
  begin
    sys_ack_o <= sys_wen_i | sys_ren_i;                // Fixed 1 cycle answer
    sys_err_o <= (sys_wen_i | sys_ren_i) & ~addr_hit;
    if (sys_wen_i)
    begin
      case (sys_addr_i)
        REG_CTRL: digital_loop_o <= sys_wdata_i[0];
        REG_PWM0: duty_o[0]      <= sys_wdata_i[PWM_W-1:0];
        REG_PWM1: duty_o[1]      <= sys_wdata_i[PWM_W-1:0];
        REG_PWM2: duty_o[2]      <= sys_wdata_i[PWM_W-1:0];
        REG_PWM3: duty_o[3]      <= sys_wdata_i[PWM_W-1:0];
        default:  ;              // REG_ID and holes ignored
      endcase
    end
  end
end

// Read data valid with the ack only
always_ff @(posedge adc_clk)
  sys_rdata_o <= sys_ren_i ? rd_data : '0;

//////////////////////////////////////////////////////////////////////
// Assertions
//////////////////////////////////////////////////////////////////////

// Error only together with an ack, holes read back zero
a_err_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  sys_err_o |-> (sys_ack_o && sys_rdata_o == '0))
  else $error("sys_err_o without ack or with nonzero read data");

a_strobe_excl: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  !(sys_wen_i && sys_ren_i))
  else $error("wen and ren high together");

endmodule

// File: hdl/afe_reset_seq.sv
//////////////////////////////////////////////////////////////////////
// Reset sequencer
// Waits for PLL lock, releases the core, then holds the DAC
// in reset for a fixed number of cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_reset_seq import afe_pkg::*; (
  input  logic adc_clk,
  input  logic rst_n_i,       // Synchronous, active low
  input  logic pll_locked_i,
  output logic core_rstn_o,   // Active low
  output logic dac_rst_o      // Active high
);

rst_state_e           state;
logic [DAC_CNT_W-1:0] hold_cnt;  // DAC hold length counter

always_ff @(posedge adc_clk)
begin
  // Lost lock acts as a reset
  if (!rst_n_i || !pll_locked_i)
  begin
    state    <= ST_WAIT_LOCK;
    hold_cnt <= '0;
  end
  else
  begin
    case (state)
      ST_WAIT_LOCK:
      begin
        state    <= ST_DAC_RST;  // Lock seen
        hold_cnt <= '0;
      end
      ST_DAC_RST:
      begin
        if (hold_cnt == DAC_CNT_W'(DAC_RST_CYCLES - 1))
          state <= ST_RUN;
        hold_cnt <= hold_cnt + 1'b1;
      end
      default: state <= ST_RUN;  // Stay until lock or reset drops
    endcase
  end
end

assign core_rstn_o = (state != ST_WAIT_LOCK);
assign dac_rst_o   = (state != ST_RUN);

//////////////////////////////////////////////////////////////////////
// Assertions
//////////////////////////////////////////////////////////////////////

// DAC leaves reset only at the end of a full hold
a_dac_rst_exit: assert property (@(posedge adc_clk)
  $fell(dac_rst_o) |->
    $past(state == ST_DAC_RST && hold_cnt == DAC_CNT_W'(DAC_RST_CYCLES - 1)))
  else $error("dac_rst_o fell before the full hold count");

// Full hold length after the core is released
a_dac_rst_hold: assert property (@(posedge adc_clk)
  $rose(core_rstn_o) |-> dac_rst_o [*DAC_RST_CYCLES])
  else $error("DAC reset hold shorter than DAC_RST_CYCLES");

endmodule

// File: hdl/afe_top.sv
//////////////////////////////////////////////////////////////////////
// Analog front end top level
// Reset sequencer, register block, ADC front end, DAC mixer
// and four PWM DAC channels on one shared period timer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_top import afe_pkg::*; (
  // Clock and reset
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  logic                    pll_locked_i,
  // ADC pins and generator / feedback samples
  input  logic [ADC_RAW_W-1:0]    adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0]    adc_dat_b_i,
  input  smp_t                    gen_a_i,
  input  smp_t                    gen_b_i,
  input  smp_t                    fb_a_i,
  input  smp_t                    fb_b_i,
  // Converted ADC samples
  output smp_t                    adc_a_o,
  output smp_t                    adc_b_o,
  // DAC
  output logic [SMP_W-1:0]        dac_dat_a_o,
  output logic [SMP_W-1:0]        dac_dat_b_o,
  output logic                    dac_rst_o,
  // PWM DACs
  output logic [PWM_N-1:0]        pwm_o,
  // Strobe bus
  input  logic [BUS_AW-1:0]       sys_addr_i,
  input  logic [BUS_DW-1:0]       sys_wdata_i,
  input  logic                    sys_wen_i,
  input  logic                    sys_ren_i,
  output logic [BUS_DW-1:0]       sys_rdata_o,
  output logic                    sys_ack_o,
  output logic                    sys_err_o
);

//////////////////////////////////////////////////////////////////////
// Local wires
//////////////////////////////////////////////////////////////////////

logic                          core_rstn;     // Low only while waiting for lock
logic                          digital_loop;
logic [PWM_N-1:0][PWM_W-1:0]   duty;
smp_t                          sat_a, sat_b;  // Saturated mixer samples
logic [PWM_W-1:0]              pwm_cnt;
logic                          period_start;

//////////////////////////////////////////////////////////////////////
// Reset and registers
//////////////////////////////////////////////////////////////////////

afe_reset_seq i_reset_seq (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .pll_locked_i (pll_locked_i),
  .core_rstn_o  (core_rstn   ),
  .dac_rst_o    (dac_rst_o   )
);

afe_regs i_regs (
  .adc_clk        (adc_clk     ),
  .rst_n_i        (core_rstn   ),
  .sys_addr_i     (sys_addr_i  ),
  .sys_wdata_i    (sys_wdata_i ),
  .sys_wen_i      (sys_wen_i   ),
  .sys_ren_i      (sys_ren_i   ),
  .sys_rdata_o    (sys_rdata_o ),
  .sys_ack_o      (sys_ack_o   ),
  .sys_err_o      (sys_err_o   ),
  .digital_loop_o (digital_loop),
  .duty_o         (duty        )
);

//////////////////////////////////////////////////////////////////////
// Analog paths
//////////////////////////////////////////////////////////////////////

adc_frontend i_adc (
  .adc_clk        (adc_clk     ),
  .rst_n_i        (core_rstn   ),
  .adc_dat_a_i    (adc_dat_a_i ),
  .adc_dat_b_i    (adc_dat_b_i ),
  .digital_loop_i (digital_loop),
  .loop_a_i       (sat_a       ),  // DAC sample fed back
  .loop_b_i       (sat_b       ),
  .adc_a_o        (adc_a_o     ),
  .adc_b_o        (adc_b_o     )
);

dac_mixer i_dac (
  .adc_clk     (adc_clk    ),
  .dac_rst_i   (dac_rst_o  ),
  .gen_a_i     (gen_a_i    ),
  .gen_b_i     (gen_b_i    ),
  .fb_a_i      (fb_a_i     ),
  .fb_b_i      (fb_b_i     ),
  .sat_a_o     (sat_a      ),
  .sat_b_o     (sat_b      ),
  .dac_dat_a_o (dac_dat_a_o),
  .dac_dat_b_o (dac_dat_b_o)
);

//////////////////////////////////////////////////////////////////////
// PWM DACs
//////////////////////////////////////////////////////////////////////

pwm_timer i_pwm_timer (
  .adc_clk        (adc_clk     ),
  .rst_n_i        (core_rstn   ),
  .cnt_o          (pwm_cnt     ),
  .period_start_o (period_start)
);

for (genvar i = 0; i < PWM_N; i++)
begin : g_pwm
  pwm_channel i_pwm (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (core_rstn   ),
    .duty_i         (duty[i]     ),
    .cnt_i          (pwm_cnt     ),
    .period_start_i (period_start),
    .pwm_o          (pwm_o[i]    )
  );
end

endmodule

// File: pwm/pwm_channel.sv
//////////////////////////////////////////////////////////////////////
// PWM channel
// Duty buffered at period start, compared against the shared count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pwm_channel import afe_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [PWM_W-1:0] duty_i,          // From register block
  input  logic [PWM_W-1:0] cnt_i,
  input  logic             period_start_i,
  output logic             pwm_o
);

logic [PWM_W-1:0] duty_q;    // Duty of the running period
logic [PWM_W-1:0] duty_cur;

// New duty already valid at count 0
assign duty_cur = period_start_i ? duty_i : duty_q;

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    duty_q <= '0;
    pwm_o  <= 1'b0;
  end
  else
  begin
    if (period_start_i)
      duty_q <= duty_i;
    pwm_o <= (cnt_i < duty_cur);  // Exactly duty high cycles per period
  end
end

// Zero duty gives a silent period
a_zero_duty: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (period_start_i && duty_i == '0) |=> !pwm_o [*PWM_PERIOD])
  else $error("pwm_o high in a zero duty period");

endmodule

// File: pwm/pwm_timer.sv
//////////////////////////////////////////////////////////////////////
// PWM period timer
// Free-running counter shared by all PWM channels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pwm_timer import afe_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  output logic [PWM_W-1:0] cnt_o,          // 0 .. PWM_PERIOD-1
  output logic             period_start_o  // High while count is 0
);

// Wraps naturally at the counter width
always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
    cnt_o <= '0;
  else
    cnt_o <= cnt_o + 1'b1;
end

assign period_start_o = (cnt_o == '0);

endmodule

// File: sim/afe_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
// Free-running clock, active low reset held for a few cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

initial
  clk_o = 1'b0;

always #(PERIOD_NS / 2) clk_o = ~clk_o;

// Released on a rising edge like any other input
initial
begin
  rst_n_o = 1'b0;
  repeat (RST_CYCLES) @(posedge clk_o);
  rst_n_o <= 1'b1;
end

endmodule

// File: sim/afe_tb.sv
//////////////////////////////////////////////////////////////////////
// Analog front end testbench
// Reset sequence, ADC conversion, DAC mixing, register access,
// digital loopback and PWM duty, each from its own table
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_tb import afe_pkg::*; ();

localparam int SMP_MAX     = 2**(SMP_W-1) - 1;           // +8191
localparam int SMP_MIN     = -(2**(SMP_W-1));            // -8192
localparam int RAND_N      = 4;                          // Random rows per table
localparam int TEST_CYCLES = 250 + 4 * 3 * PWM_PERIOD;   // PWM test dominates
localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
localparam int REG_N       = 18;

typedef struct packed {
  logic [ADC_RAW_W-1:0] a;
  logic [ADC_RAW_W-1:0] b;
} adc_vec_t;

typedef struct packed {
  int gen_a;
  int fb_a;
  int gen_b;
  int fb_b;
} mix_t;

typedef struct packed {
  logic              wr;
  logic [BUS_AW-1:0] addr;
  logic [BUS_DW-1:0] wdata;
  logic [BUS_DW-1:0] rdata;  // Checked on reads only
  logic              err;
} reg_op_t;

//////////////////////////////////////////////////////////////////////
// DUT signals and tables
//////////////////////////////////////////////////////////////////////

logic                 adc_clk, rst_n, pll_locked;
logic [ADC_RAW_W-1:0] adc_dat_a, adc_dat_b;
smp_t                 gen_a, gen_b, fb_a, fb_b;
smp_t                 adc_a, adc_b;
logic [SMP_W-1:0]     dac_dat_a, dac_dat_b;
logic                 dac_rst;
logic [PWM_N-1:0]     pwm;
logic [BUS_AW-1:0]    sys_addr;
logic [BUS_DW-1:0]    sys_wdata, sys_rdata;
logic                 sys_wen, sys_ren, sys_ack, sys_err;

adc_vec_t adc_tab  [$];
mix_t     dac_tab  [$];
mix_t     loop_tab [$];
int       lock_gap_tab [2] = '{1, 3};  // Cycles with lock lost
logic [PWM_W-1:0]  duty_tab [4]     = '{8'd0, 8'd1, 8'd128, 8'd255};
logic [BUS_AW-1:0] pwm_addr [PWM_N] = '{REG_PWM0, REG_PWM1, REG_PWM2, REG_PWM3};

reg_op_t reg_tab [REG_N] = '{
  '{1'b0, REG_ID,   32'h0,         AFE_ID,   1'b0},
  '{1'b1, REG_CTRL, 32'h1,         32'h0,    1'b0},
  '{1'b0, REG_CTRL, 32'h0,         32'h1,    1'b0},
  '{1'b1, REG_CTRL, 32'hFFFF_FFFE, 32'h0,    1'b0},  // Only bit 0 stored
  '{1'b0, REG_CTRL, 32'h0,         32'h0,    1'b0},
  '{1'b1, REG_PWM0, 32'h5A,        32'h0,    1'b0},
  '{1'b1, REG_PWM1, 32'h1A5,       32'h0,    1'b0},  // Upper bits dropped
  '{1'b1, REG_PWM2, 32'hFF,        32'h0,    1'b0},
  '{1'b1, REG_PWM3, 32'h01,        32'h0,    1'b0},
  '{1'b0, REG_PWM0, 32'h0,         32'h5A,   1'b0},
  '{1'b0, REG_PWM1, 32'h0,         32'hA5,   1'b0},
  '{1'b0, REG_PWM2, 32'h0,         32'hFF,   1'b0},
  '{1'b0, REG_PWM3, 32'h0,         32'h01,   1'b0},
  '{1'b1, REG_ID,   32'h1234_5678, 32'h0,    1'b0},  // Read only, no error
  '{1'b0, REG_ID,   32'h0,         AFE_ID,   1'b0},
  '{1'b0, 8'h08,    32'h0,         32'h0,    1'b1},  // Holes in the map
  '{1'b1, 8'h20,    32'hDEAD,      32'h0,    1'b1},
  '{1'b0, 8'hFC,    32'h0,         32'h0,    1'b1}
};

int    n_checks  = 0;
int    n_errors  = 0;
int    n_tests   = 0;
int    chk0      = 0;
int    err0      = 0;
int    cycle_cnt = 0;
string cur_test;

afe_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) i_clk_gen (
  .clk_o   (adc_clk),
  .rst_n_o (rst_n  )
);

afe_top dut_i (
  .adc_clk      (adc_clk   ),
  .rst_n_i      (rst_n     ),
  .pll_locked_i (pll_locked),
  .adc_dat_a_i  (adc_dat_a ),
  .adc_dat_b_i  (adc_dat_b ),
  .gen_a_i      (gen_a     ),
  .gen_b_i      (gen_b     ),
  .fb_a_i       (fb_a      ),
  .fb_b_i       (fb_b      ),
  .adc_a_o      (adc_a     ),
  .adc_b_o      (adc_b     ),
  .dac_dat_a_o  (dac_dat_a ),
  .dac_dat_b_o  (dac_dat_b ),
  .dac_rst_o    (dac_rst   ),
  .pwm_o        (pwm       ),
  .sys_addr_i   (sys_addr  ),
  .sys_wdata_i  (sys_wdata ),
  .sys_wen_i    (sys_wen   ),
  .sys_ren_i    (sys_ren   ),
  .sys_rdata_o  (sys_rdata ),
  .sys_ack_o    (sys_ack   ),
  .sys_err_o    (sys_err   )
);

//////////////////////////////////////////////////////////////////////
// Reference rules and check helpers
//////////////////////////////////////////////////////////////////////

// Bits 15..2 as a negative-slope code, 0 is full positive scale
function automatic int adc_value(input logic [ADC_RAW_W-1:0] raw);
  return SMP_MAX - int'(raw[ADC_RAW_W-1:2]);
endfunction

function automatic int sat_sum(input int g, input int f);
  if (g + f > SMP_MAX)
    return SMP_MAX;
  if (g + f < SMP_MIN)
    return SMP_MIN;
  return g + f;
endfunction

function automatic int dac_code(input int s);
  return SMP_MAX - s;  // Same negative slope as the ADC
endfunction

// Half scale so the sum never saturates
function automatic int rand_smp();
  return int'($urandom_range(SMP_MAX)) - (SMP_MAX + 1) / 2;
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  n_checks++;
  assert (got === exp)
  else
  begin
    $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    n_errors++;
  end
endtask

task automatic check_true(input logic cond, input string msg);
  n_checks++;
  assert (cond)
  else
  begin
    $display("%s", msg);
    n_errors++;
  end
endtask

task automatic test_begin(input string name);
  cur_test = name;
  chk0     = n_checks;
  err0     = n_errors;
  n_tests++;
endtask

task automatic test_end();
  $display("Test %0d %s: %s (%0d checks, %0d errors)", n_tests, cur_test,
           (n_errors == err0) ? "PASS" : "FAIL", n_checks - chk0, n_errors - err0);
endtask

task automatic build_tables();
  adc_tab.push_back(adc_vec_t'{16'h0000, 16'hFFFF});  // Both ends of scale
  adc_tab.push_back(adc_vec_t'{16'h8000, 16'h7FFF});  // Around mid-scale
  adc_tab.push_back(adc_vec_t'{16'h7FFC, 16'h8003});  // Reserved bits set
  adc_tab.push_back(adc_vec_t'{16'h1234, 16'hABCD});
  dac_tab.push_back(mix_t'{SMP_MAX, SMP_MAX, SMP_MIN, SMP_MIN});  // Hard overflow
  dac_tab.push_back(mix_t'{SMP_MAX, 1, SMP_MIN, -1});            // Over by one
  dac_tab.push_back(mix_t'{4096, 4095, -4096, -4096});           // Exact full scale
  dac_tab.push_back(mix_t'{0, 0, -1, 0});
  dac_tab.push_back(mix_t'{100, -300, 5000, -5000});
  loop_tab.push_back(mix_t'{SMP_MAX, SMP_MAX, -3000, -6000});    // Both saturate
  loop_tab.push_back(mix_t'{1000, 2000, SMP_MIN, 100});
  loop_tab.push_back(mix_t'{-8000, -500, 8000, 500});
  repeat (RAND_N)
  begin
    adc_tab.push_back(adc_vec_t'{ADC_RAW_W'($urandom), ADC_RAW_W'($urandom)});
    dac_tab.push_back(mix_t'{rand_smp(), rand_smp(), rand_smp(), rand_smp()});
    loop_tab.push_back(mix_t'{rand_smp(), rand_smp(), rand_smp(), rand_smp()});
  end
endtask

// One strobe, ack due exactly one cycle later
task automatic bus_access(input reg_op_t op);
  @(posedge adc_clk);
  sys_addr  <= op.addr;
  sys_wdata <= op.wdata;
  sys_wen   <= op.wr;
  sys_ren   <= !op.wr;
  @(negedge adc_clk);
  check_val("sys_ack_o", 32'(sys_ack), 32'h0);  // Not in the strobe cycle
  @(posedge adc_clk);
  sys_wen <= 1'b0;
  sys_ren <= 1'b0;
  @(negedge adc_clk);
  check_val("sys_ack_o", 32'(sys_ack), 32'h1);
  check_val("sys_err_o", 32'(sys_err), 32'(op.err));
  if (!op.wr)
    check_val("sys_rdata_o", sys_rdata, op.rdata);
endtask

// Called on the edge that raises lock
task automatic measure_dac_hold();
  int cycles;
  cycles = 0;
  @(posedge adc_clk);  // Sequencer leaves ST_WAIT_LOCK
  @(negedge adc_clk);
  while (dac_rst && cycles <= 4 * DAC_RST_CYCLES)
  begin
    @(negedge adc_clk);
    cycles++;
  end
  if (dac_rst)
    check_true(1'b0, "dac_rst_o never fell after PLL lock was seen");
  else
    check_val("dac_rst_o hold cycles", cycles, DAC_RST_CYCLES);
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic reset_test();
  test_begin("reset sequence");
  while (rst_n !== 1'b1)
    @(posedge adc_clk);
  @(negedge adc_clk);
  check_val("dac_rst_o", 32'(dac_rst), 32'h1);  // Inactive state, lock still low
  check_val("sys_ack_o", 32'(sys_ack), 32'h0);
  check_val("sys_err_o", 32'(sys_err), 32'h0);
  check_val("pwm_o", 32'(pwm), 32'h0);
  @(posedge adc_clk);
  pll_locked <= 1'b1;
  measure_dac_hold();
  foreach (lock_gap_tab[i])
  begin
    @(posedge adc_clk);
    pll_locked <= 1'b0;
    @(negedge adc_clk);
    check_val("dac_rst_o", 32'(dac_rst), 32'h0);
    @(negedge adc_clk);
    check_val("dac_rst_o", 32'(dac_rst), 32'h1);  // Next edge after lock loss
    repeat (lock_gap_tab[i]) @(posedge adc_clk);
    pll_locked <= 1'b1;
    measure_dac_hold();
  end
  test_end();
endtask

task automatic adc_test();
  test_begin("ADC conversion");
  foreach (adc_tab[i])
  begin
    @(posedge adc_clk);
    adc_dat_a <= adc_tab[i].a;
    adc_dat_b <= adc_tab[i].b;
    @(posedge adc_clk);  // Pin register
    @(negedge adc_clk);
    check_val("adc_a_o", 32'(adc_a), adc_value(adc_tab[i].a));
    check_val("adc_b_o", 32'(adc_b), adc_value(adc_tab[i].b));
  end
  test_end();
endtask

task automatic dac_test();
  test_begin("DAC mixing");
  foreach (dac_tab[i])
  begin
    @(posedge adc_clk);
    gen_a <= smp_t'(dac_tab[i].gen_a);
    fb_a  <= smp_t'(dac_tab[i].fb_a);
    gen_b <= smp_t'(dac_tab[i].gen_b);
    fb_b  <= smp_t'(dac_tab[i].fb_b);
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_val("dac_dat_a_o", 32'(dac_dat_a), dac_code(sat_sum(dac_tab[i].gen_a, dac_tab[i].fb_a)));
    check_val("dac_dat_b_o", 32'(dac_dat_b), dac_code(sat_sum(dac_tab[i].gen_b, dac_tab[i].fb_b)));
  end
  test_end();
endtask

task automatic reg_test();
  test_begin("register access");
  foreach (reg_tab[i])
    bus_access(reg_tab[i]);
  test_end();
endtask

task automatic loop_test();
  test_begin("loopback");
  bus_access(reg_op_t'{1'b1, REG_CTRL, 32'h1, 32'h0, 1'b0});
  foreach (loop_tab[i])
  begin
    @(posedge adc_clk);
    gen_a <= smp_t'(loop_tab[i].gen_a);
    fb_a  <= smp_t'(loop_tab[i].fb_a);
    gen_b <= smp_t'(loop_tab[i].gen_b);
    fb_b  <= smp_t'(loop_tab[i].fb_b);
    @(negedge adc_clk);  // Same cycle, no register
    check_val("adc_a_o", 32'(adc_a), sat_sum(loop_tab[i].gen_a, loop_tab[i].fb_a));
    check_val("adc_b_o", 32'(adc_b), sat_sum(loop_tab[i].gen_b, loop_tab[i].fb_b));
  end
  bus_access(reg_op_t'{1'b1, REG_CTRL, 32'h0, 32'h0, 1'b0});
  test_end();
endtask

// Each channel gets a different duty, rotated per row
task automatic pwm_test();
  int high_cnt [PWM_N];
  test_begin("PWM duty");
  foreach (duty_tab[i])
  begin
    for (int ch = 0; ch < PWM_N; ch++)
    begin
      bus_access(reg_op_t'{1'b1, pwm_addr[ch], 32'(duty_tab[(i + ch) % 4]), 32'h0, 1'b0});
      high_cnt[ch] = 0;
    end
    repeat (PWM_PERIOD + 2) @(posedge adc_clk);  // New duty loaded everywhere
    repeat (PWM_PERIOD)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < PWM_N; ch++)
        high_cnt[ch] += int'(pwm[ch]);
    end
    for (int ch = 0; ch < PWM_N; ch++)
      check_val($sformatf("pwm_o[%0d] high cycles", ch), high_cnt[ch],
                32'(duty_tab[(i + ch) % 4]));
  end
  test_end();
endtask

//////////////////////////////////////////////////////////////////////
// Run control
//////////////////////////////////////////////////////////////////////

always @(posedge adc_clk)
begin
  cycle_cnt <= cycle_cnt + 1;
  if (cycle_cnt >= MAX_CYCLES)
  begin
    $display("Timeout, run stopped after %0d cycles", cycle_cnt);
    $display("tests failed");
    $finish;
  end
end

initial
begin
  void'($urandom(32'hf0a1));  // Single seed for the run
  pll_locked = 1'b0;
  adc_dat_a  = '0;
  adc_dat_b  = '0;
  gen_a      = '0;
  gen_b      = '0;
  fb_a       = '0;
  fb_b       = '0;
  sys_addr   = '0;
  sys_wdata  = '0;
  sys_wen    = 1'b0;
  sys_ren    = 1'b0;
  build_tables();
  reset_test();
  adc_test();
  dac_test();
  reg_test();
  loop_test();
  pwm_test();
  $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
  if (n_errors == 0)
    $display("all tests passed");
  else
    $display("tests failed");
  $finish;
end

endmodule

// File: vlog.f
common/afe_pkg.sv
hdl/afe_reset_seq.sv
hdl/afe_regs.sv
analog/adc_frontend.sv
analog/dac_mixer.sv
pwm/pwm_timer.sv
pwm/pwm_channel.sv
hdl/afe_top.sv
sim/afe_clk_gen.sv
sim/afe_tb.sv
